// File: compile.f
hdl/mem_pkg.sv
hdl/data_ram.sv
hdl/store_lane_gen.sv
hdl/load_lane_extract.sv
hdl/mem_access_ctrl.sv
hdl/data_mem_top.sv
testbench/tb_data_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the data memory testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f compile.f \
    --top-module tb_data_mem \
    -Mdir obj_dir \
    -o Vtb_data_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_data_mem > "$log" 2>&1
status=$?
cat "$log"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "Test failed" "$log"; then
    exit 1
fi

exit 0

// File: testbench/tb_data_mem.sv
// ****************************************
// data memory testbench
// random and directed loads and stores on
// the req/ack port, checked against a byte
// level model of the ram window
// ****************************************

`timescale 1ns/1ps

module tb_data_mem;

    // dut defaults repeated here
    localparam logic [63:0] ram_base      = 64'h0000_0000_8000_0000;
    localparam int          ram_addr_bits = 9;
    localparam int          pair_count    = 1 << ram_addr_bits;
    localparam int          ram_bytes     = pair_count * 8;
    localparam logic [63:0] ram_end       = ram_base + 64'(ram_bytes);
    localparam int          clk_period    = 40;

    // transactions for init, round trip, extension, lanes, misaligned and range
    localparam int rt_rounds       = 50;
    localparam int total_txns      = pair_count + 3 * rt_rounds + 29 + 5 + 36 + 10;
    localparam int watchdog_cycles = total_txns * 20 + 200;

    logic              clk;
    logic              rst;
    logic              req;
    mem_pkg::mem_req_t req_data;
    logic              ack;
    mem_pkg::mem_rsp_t rsp;

    logic [7:0]        model [0:ram_bytes-1];
    logic [15:0]       lfsr_state;
    int                error_count;
    mem_pkg::mem_rsp_t expected_q [$];
    mem_pkg::mem_rsp_t exp_rsp;
    logic              ack_prev;

    data_mem_top #(
        .ram_base      (ram_base),
        .ram_addr_bits (ram_addr_bits)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic mem_pkg::mem_req_t make_req(input mem_pkg::mem_op_e op,
        input mem_pkg::width_e w, input logic uns, input logic [63:0] addr,
        input logic [63:0] data);
        mem_pkg::mem_req_t r;
        r.op          = op;
        r.width       = w;
        r.is_unsigned = uns;
        r.addr        = addr;
        r.wdata       = data;
        return r;
    endfunction

    // expected response and model update on ok stores
    function automatic mem_pkg::mem_rsp_t ref_access(input mem_pkg::mem_req_t r);
        mem_pkg::mem_rsp_t res;
        int                size;
        int                idx;
        logic [64:0]       last_byte;
        logic [63:0]       value;
        res  = '0;
        size = 1 << int'(r.width);
        // extra top bit so addresses near 2^64 cannot wrap
        last_byte = {1'b0, r.addr} + 65'(size - 1);
        if (r.addr < ram_base || last_byte >= {1'b0, ram_end}) begin
            res.status = mem_pkg::resp_range;
        end else if ((r.addr % 64'(size)) != 64'd0) begin
            res.status = mem_pkg::resp_misaligned;
        end else begin
            res.status = mem_pkg::resp_ok;
            idx   = int'(r.addr - ram_base);
            value = '0;
            // little endian with the lowest address in the low byte
            for (int i = 0; i < size; i++) begin
                if (r.op == mem_pkg::op_store) begin
                    model[idx + i] = r.wdata[8*i +: 8];
                end
                value[8*i +: 8] = model[idx + i];
            end
            if (!r.is_unsigned && size < 8 && value[8*size-1]) begin
                for (int b = 8 * size; b < 64; b++) begin
                    value[b] = 1'b1;
                end
            end
            if (r.op == mem_pkg::op_load) begin
                res.rdata = value;
            end
        end
        return res;
    endfunction

    task automatic check_rsp(input mem_pkg::mem_rsp_t got, input mem_pkg::mem_rsp_t exp);
        if (got !== exp) begin
            $display("error: %0t rsp expected %h got %h", $time, exp, got);
            error_count++;
        end
    endtask

    task automatic check_status(input mem_pkg::resp_e got, input mem_pkg::resp_e exp);
        if (got !== exp) begin
            $display("error: %0t rsp.status expected %0d got %0d", $time, exp, got);
            error_count++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string phase);
        if (got !== exp) begin
            $display("error: %0t ack (%s) expected %b got %b", $time, phase, exp, got);
            error_count++;
        end
    endtask

    // response check on each rising ack
    always @(negedge clk) begin
        if (rst) begin
            ack_prev = 1'b0;
        end else begin
            if (ack && !ack_prev) begin
                if (expected_q.size() == 0) begin
                    $display("a response arrived at %0t with no request outstanding", $time);
                    error_count++;
                end else begin
                    exp_rsp = expected_q.pop_front();
                    check_status(rsp.status, exp_rsp.status);
                    check_rsp(rsp, exp_rsp);
                end
            end
            ack_prev = ack;
        end
    end

    // one full four-phase transaction
    task automatic run_txn(input mem_pkg::mem_req_t r);
        int edges;
        int hold;
        expected_q.push_back(ref_access(r));
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        // the next edge samples req and ack follows two edges later
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!ack && edges < 12);
        if (!ack) begin
            $display("ack never rose for the request at address %h", r.addr);
            error_count++;
        end else if (edges != 4) begin
            $display("error: %0t ack latency expected 2 edges got %0d", $time, edges - 2);
            error_count++;
        end
        // random back-pressure
        hold = int'(rand_bits(3));
        repeat (hold) begin
            @(negedge clk);
            check_ack(ack, 1'b1, "req held");
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b1, "req low not yet sampled");
        @(negedge clk);
        check_ack(ack, 1'b0, "req low sampled");
    endtask

    task automatic test_round_trip();
        logic [63:0]     bits;
        logic [63:0]     addr;
        logic [63:0]     data;
        mem_pkg::width_e w;
        int              lane;
        for (int n = 0; n < rt_rounds; n++) begin
            bits = rand_bits(2);
            w    = mem_pkg::width_e'(bits[1:0]);
            bits = rand_bits(ram_addr_bits);
            // aligned lane inside the pair
            lane = int'(rand_bits(3)) & ~((1 << int'(w)) - 1);
            addr = ram_base + (bits << 3) + 64'(lane);
            data = rand_bits(64);
            run_txn(make_req(mem_pkg::op_store, w, 1'b0, addr, data));
            bits = rand_bits(1);
            run_txn(make_req(mem_pkg::op_load, w, bits[0], addr, 64'd0));
            // the whole pair catches neighbour corruption
            run_txn(make_req(mem_pkg::op_load, mem_pkg::w64, 1'b0, {addr[63:3], 3'b000}, 64'd0));
        end
    endtask

    task automatic test_extension();
        logic [63:0] addr;
        addr = ram_base + 64'd56;
        // every byte has its top bit set
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, addr, 64'hf0e1_d2c3_b4a5_9687));
        for (int wi = 0; wi < 3; wi++) begin
            for (int off = 0; off < 8; off += (1 << wi)) begin
                for (int u = 0; u < 2; u++) begin
                    run_txn(make_req(mem_pkg::op_load, mem_pkg::width_e'(2'(wi)), 1'(u),
                                     addr + 64'(off), 64'd0));
                end
            end
        end
    endtask

    task automatic test_lanes();
        logic [63:0] addr;
        addr = ram_base + 64'd160;
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, addr, 64'h1122_3344_5566_7788));
        // upper bits of wdata are junk and must be ignored
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w8, 1'b0, addr + 64'd3, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w16, 1'b0, addr + 64'd6, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w8, 1'b0, addr, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w64, 1'b0, addr, 64'd0));
    endtask

    task automatic test_misaligned();
        logic [63:0] addr;
        addr = ram_base + 64'd264;
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, addr, 64'h0123_4567_89ab_cdef));
        for (int wi = 1; wi < 4; wi++) begin
            for (int off = 0; off < 8; off++) begin
                if ((off % (1 << wi)) != 0) begin
                    run_txn(make_req(mem_pkg::op_store, mem_pkg::width_e'(2'(wi)), 1'b0,
                                     addr + 64'(off), rand_bits(64)));
                    run_txn(make_req(mem_pkg::op_load, mem_pkg::width_e'(2'(wi)), 1'b0,
                                     addr + 64'(off), 64'd0));
                end
            end
        end
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w64, 1'b0, addr, 64'd0));
    endtask

    task automatic test_range();
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, ram_end - 64'd8, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, ram_base - 64'd8, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w8, 1'b0, 64'd0, 64'd0));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w8, 1'b0, ram_end, rand_bits(64)));
        // last byte past the end so range wins over alignment
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, ram_end - 64'd4, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w16, 1'b0, ram_end - 64'd1, rand_bits(64)));
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w32, 1'b0, ram_end - 64'd2, 64'd0));
        run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, 64'hffff_ffff_ffff_fff8,
                         rand_bits(64)));
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w64, 1'b0, ram_base, 64'd0));
        run_txn(make_req(mem_pkg::op_load, mem_pkg::w64, 1'b0, ram_end - 64'd8, 64'd0));
    endtask

    initial begin
        lfsr_state  = 16'd51;
        error_count = 0;
        rst         <= 1'b1;
        req         <= 1'b0;
        req_data    <= '0;
        for (int i = 0; i < ram_bytes; i++) begin
            model[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // idle port before the first request
        repeat (3) begin
            @(negedge clk);
            check_ack(ack, 1'b0, "after reset");
        end
        check_rsp(rsp, '0);
        // zero every pair through the port to match the model
        for (int p = 0; p < pair_count; p++) begin
            run_txn(make_req(mem_pkg::op_store, mem_pkg::w64, 1'b0, ram_base + 64'(p * 8), 64'd0));
        end
        test_round_trip();
        test_extension();
        test_lanes();
        test_misaligned();
        test_range();
        repeat (4) @(negedge clk);
        if (expected_q.size() != 0) begin
            $display("%0d responses never arrived", expected_q.size());
            error_count++;
        end
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: hdl/data_mem_top.sv
// ****************************************
// data memory top
// controller, ram and the load/store lane
// units behind one req/ack port
// ****************************************

`timescale 1ns/1ps

module data_mem_top #(
    parameter logic [63:0] ram_base      = 64'h0000_0000_8000_0000,
    parameter int          ram_addr_bits = 9
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  mem_pkg::mem_req_t req_data,
    output logic              ack,
    output mem_pkg::mem_rsp_t rsp
);

    // controller to ram
    logic                       ram_en;
    logic                       ram_we;
    logic [ram_addr_bits-1:0]   pair_index;

    // latched request fields
    mem_pkg::width_e            cur_width;
    logic [2:0]                 cur_offset;
    logic                       cur_unsigned;
    logic [mem_pkg::xlen-1:0]   cur_wdata;

    // store lanes into the ram
    logic [7:0]                 be;
    logic [mem_pkg::xlen-1:0]   lane_data;

    // ram pair out, extracted load back
    logic [mem_pkg::xlen-1:0]   rdata;
    logic [mem_pkg::xlen-1:0]   load_value;

    mem_access_ctrl #(
        .ram_base      (ram_base),
        .ram_addr_bits (ram_addr_bits)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .rsp          (rsp),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .pair_index   (pair_index),
        .cur_width    (cur_width),
        .cur_offset   (cur_offset),
        .cur_unsigned (cur_unsigned),
        .cur_wdata    (cur_wdata),
        .load_value   (load_value)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) u_ram (
        .clk        (clk),
        .en         (ram_en),
        .we         (ram_we),
        .pair_index (pair_index),
        .be         (be),
        .wdata      (lane_data),
        .rdata      (rdata)
    );

    store_lane_gen u_store (
        .width      (cur_width),
        .offset     (cur_offset),
        .store_data (cur_wdata),
        .be         (be),
        .lane_data  (lane_data)
    );

    load_lane_extract u_load (
        .word        (rdata),
        .offset      (cur_offset),
        .width       (cur_width),
        .is_unsigned (cur_unsigned),
        .value       (load_value)
    );

endmodule

// File: hdl/mem_access_ctrl.sv
// ****************************************
// data memory access controller
// four-phase req/ack FSM, window range and
// alignment checks, ram sequencing and the
// response register
// ****************************************

`timescale 1ns/1ps

module mem_access_ctrl #(
    parameter logic [63:0] ram_base      = 64'h0000_0000_8000_0000,
    parameter int          ram_addr_bits = 9
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  mem_pkg::mem_req_t          req_data,
    output logic                       ack,
    output mem_pkg::mem_rsp_t          rsp,
    output logic                       ram_en,
    output logic                       ram_we,
    output logic [ram_addr_bits-1:0]   pair_index,
    output mem_pkg::width_e            cur_width,
    output logic [2:0]                 cur_offset,
    output logic                       cur_unsigned,
    output logic [mem_pkg::xlen-1:0]   cur_wdata,
    input  logic [mem_pkg::xlen-1:0]   load_value
);

    // window length in bytes with 8 per pair
    localparam logic [63:0] ram_len = 64'd8 << ram_addr_bits;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond,
        st_release
    } state_e;

    state_e            state;
    mem_pkg::mem_req_t req_q;
    mem_pkg::resp_e    status_q;

    // checks on the incoming request
    logic [63:0]       acc_size;
    logic [63:0]       new_off;
    logic              misaligned;
    logic              in_range;
    mem_pkg::resp_e    chk_status;

    // byte offset of the latched request
    logic [63:0]       req_off;

    always_comb begin
        case (req_data.width)
            mem_pkg::w8: begin
                acc_size   = 64'd1;
                misaligned = 1'b0;
            end
            mem_pkg::w16: begin
                acc_size   = 64'd2;
                misaligned = req_data.addr[0];
            end
            mem_pkg::w32: begin
                acc_size   = 64'd4;
                misaligned = |req_data.addr[1:0];
            end
            default: begin
                acc_size   = 64'd8;
                misaligned = |req_data.addr[2:0];
            end
        endcase
        new_off = req_data.addr - ram_base;
        // last byte must stay inside the window
        in_range = (req_data.addr >= ram_base) && (new_off <= ram_len - acc_size);
        // range fault wins over alignment
        if (!in_range) begin
            chk_status = mem_pkg::resp_range;
        end else if (misaligned) begin
            chk_status = mem_pkg::resp_misaligned;
        end else begin
            chk_status = mem_pkg::resp_ok;
        end
    end

    // request latch taken when idle sees req
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            req_q    <= req_data;
            status_q <= chk_status;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            ack    <= 1'b0;
            rsp    <= '0;
            ram_en <= 1'b0;
            ram_we <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        // faults skip the ram but keep the same latency
                        ram_en <= (chk_status == mem_pkg::resp_ok);
                        ram_we <= (chk_status == mem_pkg::resp_ok) &&
                                  (req_data.op == mem_pkg::op_store);
                        state  <= st_access;
                    end
                end
                st_access: begin
                    // ram registers read or commits write here
                    ram_en <= 1'b0;
                    ram_we <= 1'b0;
                    state  <= st_respond;
                end
                st_respond: begin
                    rsp.status <= status_q;
                    if (status_q == mem_pkg::resp_ok && req_q.op == mem_pkg::op_load) begin
                        rsp.rdata <= load_value;
                    end else begin
                        rsp.rdata <= '0;
                    end
                    ack   <= 1'b1;
                    state <= st_release;
                end
                st_release: begin
                    // hold ack until requester lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ram and lane units see the latched request
    assign req_off      = req_q.addr - ram_base;
    assign pair_index   = req_off[ram_addr_bits+2:3];
    assign cur_width    = req_q.width;
    assign cur_offset   = req_q.addr[2:0];
    assign cur_unsigned = req_q.is_unsigned;
    assign cur_wdata    = req_q.wdata;

endmodule

// File: hdl/load_lane_extract.sv
// ****************************************
// load lane extractor
// picks the addressed byte, half, word or
// doubleword from a pair and extends it
// ****************************************

`timescale 1ns/1ps

module load_lane_extract (
    input  logic [mem_pkg::xlen-1:0]   word,
    input  logic [2:0]                 offset,
    input  mem_pkg::width_e            width,
    input  logic                       is_unsigned,
    output logic [mem_pkg::xlen-1:0]   value
);

    // field moved down to bit 0
    logic [mem_pkg::xlen-1:0] shifted;

    // fill bit for the upper part
    logic fill;

    // byte offset times 8
    assign shifted = word >> {offset, 3'b000};

    always_comb begin
        case (width)
            mem_pkg::w8: begin
                fill  = shifted[7] & ~is_unsigned;
                value = {{56{fill}}, shifted[7:0]};
            end
            mem_pkg::w16: begin
                fill  = shifted[15] & ~is_unsigned;
                value = {{48{fill}}, shifted[15:0]};
            end
            mem_pkg::w32: begin
                fill  = shifted[31] & ~is_unsigned;
                value = {{32{fill}}, shifted[31:0]};
            end
            default: begin
                // w64 fills nothing and ignores the sign flag
                fill  = 1'b0;
                value = shifted;
            end
        endcase
    end

    // for w64 the offset is always zero
    // once alignment has passed, so shifted
    // equals word here

endmodule

// File: hdl/store_lane_gen.sv
// ****************************************
// store lane generator
// builds byte enables and lane-aligned
// write data for 8/16/32/64-bit stores
// ****************************************

`timescale 1ns/1ps

module store_lane_gen (
    input  mem_pkg::width_e            width,
    input  logic [2:0]                 offset,
    input  logic [mem_pkg::xlen-1:0]   store_data,
    output logic [7:0]                 be,
    output logic [mem_pkg::xlen-1:0]   lane_data
);

    // unshifted enable pattern for the width
    logic [7:0] base_be;

    // low field copied into every aligned lane
    // and the byte enables pick the one written
    always_comb begin
        case (width)
            mem_pkg::w8: begin
                base_be   = 8'h01;
                lane_data = {8{store_data[7:0]}};
            end
            mem_pkg::w16: begin
                base_be   = 8'h03;
                lane_data = {4{store_data[15:0]}};
            end
            mem_pkg::w32: begin
                base_be   = 8'h0f;
                lane_data = {2{store_data[31:0]}};
            end
            default: begin
                // w64
                base_be   = 8'hff;
                lane_data = store_data;
            end
        endcase
    end

    // offset is aligned by the controller
    // so the pattern never wraps
    assign be = base_be << offset;

endmodule

// File: hdl/data_ram.sv
// ****************************************
// data ram
// 32-bit word array accessed as aligned
// word pairs, registered 64-bit read and
// byte-enabled writes
// ****************************************

`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_bits = 9
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     we,
    input  logic [ram_addr_bits-1:0] pair_index,
    input  logic [7:0]               be,
    input  logic [63:0]              wdata,
    output logic [63:0]              rdata
);

    // two words per pair
    localparam int word_count = 2 ** (ram_addr_bits + 1);

    logic [31:0] mem [0:word_count-1];

    // low word at the even index
    logic [ram_addr_bits:0] lo_index;
    logic [ram_addr_bits:0] hi_index;

    assign lo_index = {pair_index, 1'b0};
    assign hi_index = {pair_index, 1'b1};

    // read side with one cycle latency
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata[31:0]  <= mem[lo_index];
            rdata[63:32] <= mem[hi_index];
        end
    end

    // write side commits on the enable edge
    // enables 0..3 hit the even word
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[lo_index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // enables 4..7 hit the odd word
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b+4]) begin
                    mem[hi_index][8*b +: 8] <= wdata[32+8*b +: 8];
                end
            end
        end
    end

    // contents undefined until written
    // through the port

endmodule

// File: hdl/mem_pkg.sv
// ****************************************
// data memory shared types
// access width, op and status encodings,
// request and response structs for the
// req/ack data memory port
// ****************************************

package mem_pkg;

    // data path width of the core
    localparam int xlen = 64;

    // access size as log2 of the byte count
    typedef enum logic [1:0] {
        w8  = 2'd0,
        w16 = 2'd1,
        w32 = 2'd2,
        w64 = 2'd3
    } width_e;

    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // response status with 2'd3 unused
    typedef enum logic [1:0] {
        resp_ok         = 2'd0,
        resp_misaligned = 2'd1,
        resp_range      = 2'd2
    } resp_e;

    // one load or store request
    typedef struct packed {
        mem_op_e          op;
        width_e           width;
        // load zero-extends when set
        logic             is_unsigned;
        // byte address
        logic [xlen-1:0]  addr;
        // store value sits in the low bits
        logic [xlen-1:0]  wdata;
    } mem_req_t;

    // rdata is zero for stores and faults
    typedef struct packed {
        resp_e            status;
        logic [xlen-1:0]  rdata;
    } mem_rsp_t;

endpackage
